/* Bender.yml */
package:
  name: coproc_front_end

sources:
  - coproc_cfg_pkg.sv
  - coproc_isa_pkg.sv
  - coproc_ram.sv
  - coproc_inst_counter.sv
  - coproc_sequencer.sv
  - coproc_axi_bridge.sv
  - coproc_top.sv
  - target: simulation
    files:
      - tb_coproc_top.sv

/* all.f */
coproc_cfg_pkg.sv
coproc_isa_pkg.sv
coproc_ram.sv
coproc_inst_counter.sv
coproc_sequencer.sv
coproc_axi_bridge.sv
coproc_top.sv
tb_coproc_top.sv

/* coproc_axi_bridge.sv */
`timescale 1ns/100ps

module coproc_axi_bridge
  import coproc_cfg_pkg::*;
#(
  parameter int INST_RAM_DEPTH = 256,
  parameter int DATA_RAM_DEPTH = 256,
  localparam int INST_AW = $clog2(INST_RAM_DEPTH),
  localparam int DATA_AW = $clog2(DATA_RAM_DEPTH)
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  logic [31:0]           i_araddr,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [31:0]           o_rdata,
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  logic [31:0]           i_awaddr,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  logic [31:0]           i_wdata,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output logic [INST_AW-1:0]    o_inst_addr,
  output logic [RAM_WORD_W-1:0] o_inst_wdata,
  output logic                  o_inst_we,
  input  logic [RAM_WORD_W-1:0] i_inst_rdata,
  output logic [DATA_AW-1:0]    o_data_addr,
  output logic [RAM_WORD_W-1:0] o_data_wdata,
  output logic                  o_data_we,
  input  logic [RAM_WORD_W-1:0] i_data_rdata,
  input  logic [31:0]           i_curr_inst_pt,
  input  logic [31:0]           i_last_inst_cnt,
  input  logic                  i_busy,
  output logic [31:0]           o_new_inst_pt,
  output logic                  o_new_inst_pt_val,
  output logic                  o_reset_inst_ram,
  output logic                  o_reset_data_ram
);

  logic [READ_CYCLE:0] inst_rd_sr;
  logic [READ_CYCLE:0] data_rd_sr;
  logic                idle;
  logic                wr_active;
  logic [31:0]         wr_addr;
  logic                rd_upper;
  logic                ar_hs;
  logic                aw_hs;
  logic                w_hs;
  logic [31:0]         rd_off;
  logic [31:0]         rd_word;
  logic [31:0]         wr_off;
  logic [31:0]         wr_word;
  logic                wr_upper;
  logic [31:0]         cfg_rdata;

  // Read wins over a write arriving in the same cycle
  assign o_arready = idle;
  assign o_awready = idle & ~i_arvalid;

  assign ar_hs = i_arvalid & o_arready;
  assign aw_hs = i_awvalid & o_awready;
  assign w_hs  = i_wvalid & o_wready;

  // Offsets inside whichever RAM window the address falls in
  assign rd_off   = i_araddr - ((i_araddr < DATA_AXIL_START) ? INST_AXIL_START : DATA_AXIL_START);
  assign rd_word  = rd_off / RAM_ALIGN_BYTE;
  assign wr_off   = wr_addr - ((wr_addr < DATA_AXIL_START) ? INST_AXIL_START : DATA_AXIL_START);
  assign wr_word  = wr_off / RAM_ALIGN_BYTE;
  assign wr_upper = ((wr_off % RAM_ALIGN_BYTE) == 4);

  always_comb begin
    case (i_araddr)
      32'h0:         cfg_rdata = INST_AXIL_START;
      32'h4:         cfg_rdata = DATA_AXIL_START;
      32'h8:         cfg_rdata = 32'(DATA_RAM_DEPTH * RAM_ALIGN_BYTE);
      32'hc:         cfg_rdata = 32'(INST_RAM_DEPTH * RAM_ALIGN_BYTE);
      CFG_ADDR_PTR:  cfg_rdata = i_curr_inst_pt;
      CFG_ADDR_CNT:  cfg_rdata = i_last_inst_cnt;
      CFG_ADDR_BUSY: cfg_rdata = {31'd0, i_busy};
      default:       cfg_rdata = CFG_DEFAULT_RDATA;
    endcase
  end

  // Handshake and strobe control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      idle              <= 1'b0;
      wr_active         <= 1'b0;
      o_wready          <= 1'b0;
      o_rvalid          <= 1'b0;
      o_bvalid          <= 1'b0;
      inst_rd_sr        <= '0;
      data_rd_sr        <= '0;
      o_inst_we         <= 1'b0;
      o_data_we         <= 1'b0;
      o_new_inst_pt_val <= 1'b0;
      o_reset_inst_ram  <= 1'b0;
      o_reset_data_ram  <= 1'b0;
    end else begin
      o_inst_we         <= 1'b0;
      o_data_we         <= 1'b0;
      o_new_inst_pt_val <= 1'b0;
      o_reset_inst_ram  <= 1'b0;
      o_reset_data_ram  <= 1'b0;
      inst_rd_sr        <= {inst_rd_sr[READ_CYCLE-1:0], 1'b0};
      data_rd_sr        <= {data_rd_sr[READ_CYCLE-1:0], 1'b0};

      // Take a new request only once the last response is gone
      if (ar_hs || aw_hs) begin
        idle <= 1'b0;
      end else if (!(|inst_rd_sr) && !(|data_rd_sr) && !wr_active && !o_rvalid && !o_bvalid) begin
        idle <= 1'b1;
      end

      if (o_rvalid && i_rready) o_rvalid <= 1'b0;
      if (o_bvalid && i_bready) begin
        o_bvalid  <= 1'b0;
        wr_active <= 1'b0;
      end

      if (inst_rd_sr[READ_CYCLE] || data_rd_sr[READ_CYCLE]) o_rvalid <= 1'b1;

      if (ar_hs) begin
        if (i_araddr < INST_AXIL_START) o_rvalid <= 1'b1;
        else if (i_araddr < DATA_AXIL_START) inst_rd_sr[0] <= 1'b1;
        else data_rd_sr[0] <= 1'b1;
      end

      if (aw_hs) begin
        wr_active <= 1'b1;
        o_wready  <= 1'b1;
      end

      if (w_hs) begin
        o_wready <= 1'b0;
        o_bvalid <= 1'b1;
        if (wr_addr < INST_AXIL_START) begin
          case (wr_addr)
            CFG_ADDR_CTRL: begin
              o_reset_inst_ram <= i_wdata[0];
              o_reset_data_ram <= i_wdata[1];
            end
            CFG_ADDR_PTR: o_new_inst_pt_val <= 1'b1;
            default: ;
          endcase
        end else if (wr_addr < DATA_AXIL_START) begin
          // Commit only with the upper half so the word lands whole
          o_inst_we <= wr_upper;
        end else begin
          o_data_we <= wr_upper;
        end
      end
    end
  end

  // Addresses, staging words and read data
  always_ff @(posedge i_clk) begin
    if (ar_hs) begin
      rd_upper <= ((i_araddr % RAM_ALIGN_BYTE) == 4);
      if (i_araddr < INST_AXIL_START) o_rdata <= cfg_rdata;
      else if (i_araddr < DATA_AXIL_START) o_inst_addr <= rd_word[INST_AW-1:0];
      else o_data_addr <= rd_word[DATA_AW-1:0];
    end

    if (inst_rd_sr[READ_CYCLE]) begin
      o_rdata <= rd_upper ? i_inst_rdata[RAM_WORD_W-1:32] : i_inst_rdata[31:0];
    end
    if (data_rd_sr[READ_CYCLE]) begin
      o_rdata <= rd_upper ? i_data_rdata[RAM_WORD_W-1:32] : i_data_rdata[31:0];
    end

    if (aw_hs) wr_addr <= i_awaddr;

    if (w_hs) begin
      if (wr_addr == CFG_ADDR_PTR) begin
        o_new_inst_pt <= i_wdata;
      end else if (wr_addr >= INST_AXIL_START && wr_addr < DATA_AXIL_START) begin
        o_inst_addr <= wr_word[INST_AW-1:0];
        if (wr_upper) o_inst_wdata[RAM_WORD_W-1:32] <= i_wdata;
        else o_inst_wdata[31:0] <= i_wdata;
      end else if (wr_addr >= DATA_AXIL_START) begin
        o_data_addr <= wr_word[DATA_AW-1:0];
        if (wr_upper) o_data_wdata[RAM_WORD_W-1:32] <= i_wdata;
        else o_data_wdata[31:0] <= i_wdata;
      end
    end
  end

endmodule

/* coproc_cfg_pkg.sv */
package coproc_cfg_pkg;

  // Host address map
  localparam logic [31:0] INST_AXIL_START = 32'h0000_1000;
  localparam logic [31:0] DATA_AXIL_START = 32'h0000_2000;

  // RAM word geometry shared by both RAMs
  localparam int RAM_WORD_W     = 64;
  localparam int RAM_ALIGN_BYTE = 8;

  // Shift stages from registered RAM address to usable read data
  localparam int READ_CYCLE = 2;

  // Config region offsets
  localparam logic [31:0] CFG_ADDR_CTRL = 32'h0000_0000;
  localparam logic [31:0] CFG_ADDR_PTR  = 32'h0000_0010;
  localparam logic [31:0] CFG_ADDR_CNT  = 32'h0000_0014;
  localparam logic [31:0] CFG_ADDR_BUSY = 32'h0000_0018;

  // Returned for config offsets with nothing behind them
  localparam logic [31:0] CFG_DEFAULT_RDATA = 32'h0000_beef;

endpackage

/* coproc_inst_counter.sv */
`timescale 1ns/100ps

module coproc_inst_counter (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_load,
  input  logic [31:0] i_load_pt,
  input  logic        i_step,
  input  logic        i_done,
  output logic [31:0] o_curr_inst_pt,
  output logic [31:0] o_last_inst_cnt
);

  logic [31:0] run_cnt;
  logic [31:0] run_cnt_next;

  // Count after this cycle's step, so HALT is included
  assign run_cnt_next = run_cnt + {31'd0, i_step};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_curr_inst_pt  <= '0;
      o_last_inst_cnt <= '0;
      run_cnt         <= '0;
    end else if (i_load) begin
      o_curr_inst_pt <= i_load_pt;
      run_cnt        <= '0;
    end else begin
      if (i_step) o_curr_inst_pt <= o_curr_inst_pt + 1'b1;
      run_cnt <= run_cnt_next;
      // Latch the finished run
      if (i_done) o_last_inst_cnt <= run_cnt_next;
    end
  end

endmodule

/* coproc_isa_pkg.sv */
package coproc_isa_pkg;

  // Instruction opcodes in the top byte of the instruction word
  typedef enum logic [7:0] {
    OP_NOP  = 8'h00,
    OP_ADD  = 8'h01,
    OP_SUB  = 8'h02,
    OP_COPY = 8'h03,
    OP_HALT = 8'hff
  } coproc_opcode_e;

  // Field positions in the 64-bit instruction
  localparam int OPC_MSB   = 63;
  localparam int OPC_LSB   = 56;
  localparam int DST_MSB   = 47;
  localparam int DST_LSB   = 32;
  localparam int SRC_A_MSB = 31;
  localparam int SRC_A_LSB = 16;
  localparam int SRC_B_MSB = 15;
  localparam int SRC_B_LSB = 0;

  // Sequencer states
  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_DECODE,
    S_RD_A,
    S_RD_B,
    S_EXEC,
    S_WRITE
  } seq_state_e;

endpackage

/* coproc_ram.sv */
`timescale 1ns/100ps

module coproc_ram
  import coproc_cfg_pkg::*;
#(
  parameter int DEPTH = 256,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_clear,
  output logic                  o_clear_busy,
  input  logic [AW-1:0]         i_a_addr,
  input  logic [RAM_WORD_W-1:0] i_a_wdata,
  input  logic                  i_a_we,
  output logic [RAM_WORD_W-1:0] o_a_rdata,
  input  logic [AW-1:0]         i_b_addr,
  input  logic [RAM_WORD_W-1:0] i_b_wdata,
  input  logic                  i_b_we,
  output logic [RAM_WORD_W-1:0] o_b_rdata
);

  logic [RAM_WORD_W-1:0] mem [DEPTH];
  logic [AW-1:0]         clr_addr;

  // Clear sweep writes one word per cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_clear_busy <= 1'b0;
      clr_addr     <= '0;
    end else if (i_clear) begin
      o_clear_busy <= 1'b1;
      clr_addr     <= '0;
    end else if (o_clear_busy) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == AW'(DEPTH - 1)) o_clear_busy <= 1'b0;
    end
  end

  // Port writes are dropped while the sweep owns the array
  always_ff @(posedge i_clk) begin
    if (o_clear_busy) begin
      mem[clr_addr] <= '0;
    end else begin
      if (i_a_we) mem[i_a_addr] <= i_a_wdata;
      if (i_b_we) mem[i_b_addr] <= i_b_wdata;
    end
    o_a_rdata <= mem[i_a_addr];
    o_b_rdata <= mem[i_b_addr];
  end

endmodule

/* coproc_sequencer.sv */
`timescale 1ns/100ps

module coproc_sequencer
  import coproc_cfg_pkg::*;
  import coproc_isa_pkg::*;
#(
  parameter int INST_RAM_DEPTH = 256,
  parameter int DATA_RAM_DEPTH = 256,
  localparam int INST_AW = $clog2(INST_RAM_DEPTH),
  localparam int DATA_AW = $clog2(DATA_RAM_DEPTH)
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_start,
  input  logic [31:0]           i_inst_pt,
  output logic [INST_AW-1:0]    o_inst_addr,
  input  logic [RAM_WORD_W-1:0] i_inst_rdata,
  output logic [DATA_AW-1:0]    o_data_addr,
  output logic [RAM_WORD_W-1:0] o_data_wdata,
  output logic                  o_data_we,
  input  logic [RAM_WORD_W-1:0] i_data_rdata,
  output logic                  o_step,
  output logic                  o_done,
  output logic                  o_busy
);

  seq_state_e            state;
  coproc_opcode_e        dec_op;
  coproc_opcode_e        op_q;
  logic [DATA_AW-1:0]    dst_q;
  logic [DATA_AW-1:0]    src_b_q;
  logic [RAM_WORD_W-1:0] op_a;

  // Instruction RAM follows the counter's pointer directly
  assign o_inst_addr = i_inst_pt[INST_AW-1:0];
  assign dec_op      = coproc_opcode_e'(i_inst_rdata[OPC_MSB:OPC_LSB]);
  assign o_busy      = (state != S_IDLE);
  assign o_data_we   = (state == S_WRITE);

  // Step on writeback, or straight from decode for NOP and HALT
  always_comb begin
    o_step = 1'b0;
    o_done = 1'b0;
    if (state == S_WRITE) begin
      o_step = 1'b1;
    end else if (state == S_DECODE) begin
      case (dec_op)
        OP_ADD, OP_SUB, OP_COPY: o_step = 1'b0;
        OP_HALT: begin
          o_step = 1'b1;
          o_done = 1'b1;
        end
        default: o_step = 1'b1;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:   if (i_start) state <= S_FETCH;
        S_FETCH:  state <= S_DECODE;
        S_DECODE: begin
          case (dec_op)
            OP_ADD, OP_SUB, OP_COPY: state <= S_RD_A;
            OP_HALT: state <= S_IDLE;
            // Unknown opcodes behave as NOP
            default: state <= S_FETCH;
          endcase
        end
        S_RD_A:   state <= S_RD_B;
        S_RD_B:   state <= S_EXEC;
        S_EXEC:   state <= S_WRITE;
        S_WRITE:  state <= S_FETCH;
        default:  state <= S_IDLE;
      endcase
    end
  end

  // Operand addresses and datapath
  always_ff @(posedge i_clk) begin
    case (state)
      S_DECODE: begin
        op_q        <= dec_op;
        dst_q       <= DATA_AW'(i_inst_rdata[DST_MSB:DST_LSB]);
        src_b_q     <= DATA_AW'(i_inst_rdata[SRC_B_MSB:SRC_B_LSB]);
        o_data_addr <= DATA_AW'(i_inst_rdata[SRC_A_MSB:SRC_A_LSB]);
      end
      S_RD_A: o_data_addr <= src_b_q;
      // Source A lands here and source B one cycle later
      S_RD_B: op_a <= i_data_rdata;
      S_EXEC: begin
        o_data_addr <= dst_q;
        case (op_q)
          OP_ADD:  o_data_wdata <= op_a + i_data_rdata;
          OP_SUB:  o_data_wdata <= op_a - i_data_rdata;
          default: o_data_wdata <= op_a;
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* coproc_top.sv */
`timescale 1ns/100ps

module coproc_top
  import coproc_cfg_pkg::*;
#(
  parameter int INST_RAM_DEPTH = 256,
  parameter int DATA_RAM_DEPTH = 256
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_arvalid,
  output logic        o_arready,
  input  logic [31:0] i_araddr,
  output logic        o_rvalid,
  input  logic        i_rready,
  output logic [31:0] o_rdata,
  input  logic        i_awvalid,
  output logic        o_awready,
  input  logic [31:0] i_awaddr,
  input  logic        i_wvalid,
  output logic        o_wready,
  input  logic [31:0] i_wdata,
  output logic        o_bvalid,
  input  logic        i_bready
);

  localparam int INST_AW = $clog2(INST_RAM_DEPTH);
  localparam int DATA_AW = $clog2(DATA_RAM_DEPTH);

  // Host side on port A
  logic [INST_AW-1:0]    inst_a_addr;
  logic [RAM_WORD_W-1:0] inst_a_wdata;
  logic                  inst_a_we;
  logic [RAM_WORD_W-1:0] inst_a_rdata;
  logic [DATA_AW-1:0]    data_a_addr;
  logic [RAM_WORD_W-1:0] data_a_wdata;
  logic                  data_a_we;
  logic [RAM_WORD_W-1:0] data_a_rdata;

  // Sequencer side on port B
  logic [INST_AW-1:0]    inst_b_addr;
  logic [RAM_WORD_W-1:0] inst_b_rdata;
  logic [DATA_AW-1:0]    data_b_addr;
  logic [RAM_WORD_W-1:0] data_b_wdata;
  logic                  data_b_we;
  logic [RAM_WORD_W-1:0] data_b_rdata;

  logic [31:0] curr_inst_pt;
  logic [31:0] last_inst_cnt;
  logic [31:0] new_inst_pt;
  logic        new_inst_pt_val;
  logic        reset_inst_ram;
  logic        reset_data_ram;
  logic        inst_clr_busy;
  logic        data_clr_busy;
  logic        seq_step;
  logic        seq_done;
  logic        seq_busy;
  logic        busy;

  assign busy = seq_busy | inst_clr_busy | data_clr_busy;

  coproc_axi_bridge #(
    .INST_RAM_DEPTH(INST_RAM_DEPTH),
    .DATA_RAM_DEPTH(DATA_RAM_DEPTH)
  ) u_bridge (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_arvalid(i_arvalid),
    .o_arready(o_arready),
    .i_araddr(i_araddr),
    .o_rvalid(o_rvalid),
    .i_rready(i_rready),
    .o_rdata(o_rdata),
    .i_awvalid(i_awvalid),
    .o_awready(o_awready),
    .i_awaddr(i_awaddr),
    .i_wvalid(i_wvalid),
    .o_wready(o_wready),
    .i_wdata(i_wdata),
    .o_bvalid(o_bvalid),
    .i_bready(i_bready),
    .o_inst_addr(inst_a_addr),
    .o_inst_wdata(inst_a_wdata),
    .o_inst_we(inst_a_we),
    .i_inst_rdata(inst_a_rdata),
    .o_data_addr(data_a_addr),
    .o_data_wdata(data_a_wdata),
    .o_data_we(data_a_we),
    .i_data_rdata(data_a_rdata),
    .i_curr_inst_pt(curr_inst_pt),
    .i_last_inst_cnt(last_inst_cnt),
    .i_busy(busy),
    .o_new_inst_pt(new_inst_pt),
    .o_new_inst_pt_val(new_inst_pt_val),
    .o_reset_inst_ram(reset_inst_ram),
    .o_reset_data_ram(reset_data_ram)
  );

  coproc_inst_counter u_counter (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_load(new_inst_pt_val),
    .i_load_pt(new_inst_pt),
    .i_step(seq_step),
    .i_done(seq_done),
    .o_curr_inst_pt(curr_inst_pt),
    .o_last_inst_cnt(last_inst_cnt)
  );

  coproc_sequencer #(
    .INST_RAM_DEPTH(INST_RAM_DEPTH),
    .DATA_RAM_DEPTH(DATA_RAM_DEPTH)
  ) u_sequencer (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_start(new_inst_pt_val),
    .i_inst_pt(curr_inst_pt),
    .o_inst_addr(inst_b_addr),
    .i_inst_rdata(inst_b_rdata),
    .o_data_addr(data_b_addr),
    .o_data_wdata(data_b_wdata),
    .o_data_we(data_b_we),
    .i_data_rdata(data_b_rdata),
    .o_step(seq_step),
    .o_done(seq_done),
    .o_busy(seq_busy)
  );

  // Sequencer never writes the instruction RAM
  coproc_ram #(
    .DEPTH(INST_RAM_DEPTH)
  ) u_inst_ram (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_clear(reset_inst_ram),
    .o_clear_busy(inst_clr_busy),
    .i_a_addr(inst_a_addr),
    .i_a_wdata(inst_a_wdata),
    .i_a_we(inst_a_we),
    .o_a_rdata(inst_a_rdata),
    .i_b_addr(inst_b_addr),
    .i_b_wdata('0),
    .i_b_we(1'b0),
    .o_b_rdata(inst_b_rdata)
  );

  coproc_ram #(
    .DEPTH(DATA_RAM_DEPTH)
  ) u_data_ram (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_clear(reset_data_ram),
    .o_clear_busy(data_clr_busy),
    .i_a_addr(data_a_addr),
    .i_a_wdata(data_a_wdata),
    .i_a_we(data_a_we),
    .o_a_rdata(data_a_rdata),
    .i_b_addr(data_b_addr),
    .i_b_wdata(data_b_wdata),
    .i_b_we(data_b_we),
    .o_b_rdata(data_b_rdata)
  );

endmodule

/* tb_coproc_top.sv */
`timescale 1ns/100ps

module tb_coproc_top
  import coproc_isa_pkg::*;
();

  localparam int DEPTH = 256;
  localparam logic [31:0] INST_BASE = 32'h0000_1000;
  localparam logic [31:0] DATA_BASE = 32'h0000_2000;
  localparam int PROG_LEN = 24;
  localparam int N_OPER = 16;
  // Far above the cycles that all five tests need together
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        rst;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic        awvalid;
  logic        awready;
  logic [31:0] awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;

  integer      seed;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_base = 0;
  int          stall_max = 0;
  int          cycles = 0;
  logic [63:0] ref_inst [DEPTH];
  logic [63:0] ref_data [DEPTH];
  logic [63:0] t2_word [8];
  int          t2_idx [8];

  coproc_top #(
    .INST_RAM_DEPTH(DEPTH),
    .DATA_RAM_DEPTH(DEPTH)
  ) u_coproc_top (
    .i_clk(clk),
    .i_rst(rst),
    .i_arvalid(arvalid),
    .o_arready(arready),
    .i_araddr(araddr),
    .o_rvalid(rvalid),
    .i_rready(rready),
    .o_rdata(rdata),
    .i_awvalid(awvalid),
    .o_awready(awready),
    .i_awaddr(awaddr),
    .i_wvalid(wvalid),
    .o_wready(wready),
    .i_wdata(wdata),
    .o_bvalid(bvalid),
    .i_bready(bready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timed out after %0d cycles, the run did not finish", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [63:0] make_inst(input logic [7:0] op, input int dst,
                                            input int a, input int b);
    make_inst = {op, 8'h00, 16'(dst), 16'(a), 16'(b)};
  endfunction

  // Sequential model of the program that updates ref_data and returns the count
  function automatic int run_reference(input int pt);
    int          cnt;
    logic        halted;
    logic [63:0] inst;
    logic [63:0] va;
    logic [63:0] vb;
    cnt = 0;
    halted = 1'b0;
    while (!halted && cnt < DEPTH) begin
      inst = ref_inst[pt % DEPTH];
      // Operand addresses wrap at the RAM depth
      va = ref_data[inst[23:16]];
      vb = ref_data[inst[7:0]];
      cnt++;
      case (inst[63:56])
        OP_ADD:  ref_data[inst[39:32]] = va + vb;
        OP_SUB:  ref_data[inst[39:32]] = va - vb;
        OP_COPY: ref_data[inst[39:32]] = va;
        OP_HALT: halted = 1'b1;
        default: ;
      endcase
      pt++;
    end
    return cnt;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_base) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    int   stall;
    logic seen;
    stall = 0;
    seen = 1'b0;
    if (stall_max > 0) stall = $unsigned($random(seed)) % (stall_max + 1);
    @(negedge clk);
    awvalid = 1'b1;
    awaddr = addr;
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b1;
    wdata = data;
    #1;
    while (!wready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    wvalid = 1'b0;
    // Response must wait while bready is held low
    repeat (stall) begin
      @(negedge clk);
      if (seen && !bvalid) begin
        errors++;
        $display("write to %h lost bvalid while bready was low", addr);
      end
      seen = bvalid;
    end
    bready = 1'b1;
    #1;
    while (!bvalid) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    bready = 1'b0;
    #1;
    if (bvalid) begin
      errors++;
      $display("write to %h gave more than one response", addr);
    end
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    int   stall;
    logic seen;
    stall = 0;
    seen = 1'b0;
    if (stall_max > 0) stall = $unsigned($random(seed)) % (stall_max + 1);
    @(negedge clk);
    arvalid = 1'b1;
    araddr = addr;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    repeat (stall) begin
      @(negedge clk);
      if (seen && !rvalid) begin
        errors++;
        $display("read of %h lost rvalid while rready was low", addr);
      end
      seen = rvalid;
    end
    rready = 1'b1;
    #1;
    while (!rvalid) begin
      @(negedge clk);
      #1;
    end
    data = rdata;
    @(negedge clk);
    rready = 1'b0;
    #1;
    if (rvalid) begin
      errors++;
      $display("read of %h gave more than one response", addr);
    end
  endtask

  // Lower half goes first and the upper half commits the word
  task automatic write64(input logic [31:0] base, input int idx, input logic [63:0] word);
    axil_write(base + 32'(idx * 8), word[31:0]);
    axil_write(base + 32'(idx * 8) + 32'd4, word[63:32]);
  endtask

  task automatic read64(input logic [31:0] base, input int idx, output logic [63:0] word);
    logic [31:0] lo;
    logic [31:0] hi;
    axil_read(base + 32'(idx * 8), lo);
    axil_read(base + 32'(idx * 8) + 32'd4, hi);
    word = {hi, lo};
  endtask

  task automatic wait_not_busy();
    logic [31:0] st;
    axil_read(32'h18, st);
    while (st[0]) axil_read(32'h18, st);
  endtask

  initial begin
    logic [31:0] rd;
    logic [63:0] got;
    logic [63:0] w64;
    logic [7:0]  op;
    int          base;
    int          sel;
    int          exp_cnt;
    seed = 32'hcc0fe17d;
    rst = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Window bases, sizes and an unmapped offset
    axil_read(32'h0, rd);
    if (rd !== INST_BASE) report_mismatch("config 0x0", rd, INST_BASE);
    axil_read(32'h4, rd);
    if (rd !== DATA_BASE) report_mismatch("config 0x4", rd, DATA_BASE);
    axil_read(32'h8, rd);
    if (rd !== 32'(DEPTH * 8)) report_mismatch("config 0x8", rd, DEPTH * 8);
    axil_read(32'hc, rd);
    if (rd !== 32'(DEPTH * 8)) report_mismatch("config 0xc", rd, DEPTH * 8);
    axil_read(32'h20, rd);
    if (rd !== 32'hbeef) report_mismatch("config 0x20", rd, 32'hbeef);
    end_test("config reads");

    for (int i = 0; i < 8; i++) begin
      t2_idx[i] = 32 + i * 20 + int'($unsigned($random(seed)) % 16);
      t2_word[i] = {$random(seed), $random(seed)};
      write64(INST_BASE, t2_idx[i], t2_word[i]);
      write64(DATA_BASE, t2_idx[i], ~t2_word[i]);
    end
    // Lower half alone must not reach the RAM
    axil_write(INST_BASE + 32'(t2_idx[0] * 8), $random(seed));
    axil_write(DATA_BASE + 32'(t2_idx[0] * 8), $random(seed));
    for (int i = 0; i < 8; i++) begin
      read64(INST_BASE, t2_idx[i], got);
      if (got !== t2_word[i]) report_mismatch($sformatf("inst word %0d", t2_idx[i]), got,
                                              t2_word[i]);
      read64(DATA_BASE, t2_idx[i], got);
      if (got !== ~t2_word[i]) report_mismatch($sformatf("data word %0d", t2_idx[i]), got,
                                               ~t2_word[i]);
    end
    end_test("ram window readback");

    base = $unsigned($random(seed)) % 64;
    for (int i = 0; i < N_OPER; i++) begin
      ref_data[i] = {$random(seed), $random(seed)};
      write64(DATA_BASE, i, ref_data[i]);
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      sel = $unsigned($random(seed)) % 4;
      case (sel)
        0:       op = OP_ADD;
        1:       op = OP_SUB;
        2:       op = OP_COPY;
        default: op = OP_NOP;
      endcase
      if (i == PROG_LEN - 1) op = OP_HALT;
      ref_inst[base + i] = make_inst(op, $unsigned($random(seed)) % N_OPER,
                                     $unsigned($random(seed)) % N_OPER,
                                     $unsigned($random(seed)) % N_OPER);
      write64(INST_BASE, base + i, ref_inst[base + i]);
    end
    exp_cnt = run_reference(base);
    axil_write(32'h10, 32'(base));
    wait_not_busy();
    for (int i = 0; i < N_OPER; i++) begin
      read64(DATA_BASE, i, got);
      if (got !== ref_data[i]) report_mismatch($sformatf("result word %0d", i), got,
                                               ref_data[i]);
    end
    axil_read(32'h14, rd);
    if (rd !== 32'(exp_cnt)) report_mismatch("executed count", rd, exp_cnt);
    end_test("program run");

    axil_write(32'h0, 32'h3);
    wait_not_busy();
    for (int i = 0; i < DEPTH; i += 15) begin
      read64(INST_BASE, i, got);
      if (got !== 64'd0) report_mismatch($sformatf("cleared inst word %0d", i), got, 0);
      read64(DATA_BASE, i, got);
      if (got !== 64'd0) report_mismatch($sformatf("cleared data word %0d", i), got, 0);
    end
    for (int i = 0; i < 8; i++) begin
      read64(DATA_BASE, t2_idx[i], got);
      if (got !== 64'd0) report_mismatch($sformatf("cleared data word %0d", t2_idx[i]), got, 0);
    end
    end_test("ram clear");

    stall_max = 6;
    for (int i = 0; i < 8; i++) begin
      w64 = {$random(seed), $random(seed)};
      write64(DATA_BASE, 200 + i * 6, w64);
      read64(DATA_BASE, 200 + i * 6, got);
      if (got !== w64) report_mismatch($sformatf("stalled data word %0d", 200 + i * 6), got,
                                       w64);
      axil_read(32'h8, rd);
      if (rd !== 32'(DEPTH * 8)) report_mismatch("stalled config 0x8", rd, DEPTH * 8);
    end
    stall_max = 0;
    end_test("back-pressure");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
